// ==== src/shim_pkg.sv ====
// Shared widths, fixed address map and payload types for the core data port.
// Every block of the shim refers to these by scoped names.

package shim_pkg;

  localparam int unsigned addr_width      = 32;
  localparam int unsigned data_width      = 32;
  localparam int unsigned strb_width      = data_width / 8;
  localparam int unsigned nr_tcdm         = 2;
  localparam int unsigned nr_soc          = 1;
  localparam int unsigned num_targets     = nr_tcdm + nr_soc;
  localparam int unsigned max_outstanding = 8;
  localparam int unsigned rob_id_width    = $clog2(max_outstanding);

  // Target index of the SoC port, banks take the indices below it
  localparam int unsigned soc_target = nr_tcdm;

  // Fixed address map
  localparam logic [addr_width-1:0] tcdm_base = 32'h1000_0000;
  localparam logic [addr_width-1:0] tcdm_size = 32'h0001_0000;
  localparam logic [addr_width-1:0] tcdm_end  = tcdm_base + tcdm_size;

  // Banks are word interleaved
  localparam int unsigned byte_offset_bits = $clog2(strb_width);
  localparam int unsigned tcdm_bank_bits   = $clog2(nr_tcdm);

  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_min  = 4'h7
  } amo_op_e;

  // Request as issued by the core, before a reorder ID is attached
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic                  write;
    amo_op_e               amo;
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
  } dreq_noid_t;

  // Request towards a target
  typedef struct packed {
    logic [addr_width-1:0]   addr;
    logic                    write;
    amo_op_e                 amo;
    logic [data_width-1:0]   data;
    logic [strb_width-1:0]   strb;
    logic [rob_id_width-1:0] id;
  } dreq_t;

  // Read response, tagged with the reorder ID of its request
  typedef struct packed {
    logic [data_width-1:0]   data;
    logic [rob_id_width-1:0] id;
    logic                    error;
  } dresp_t;

endpackage

// ==== src/reorder_buffer.sv ====
// Reorder buffer for read responses. IDs are handed out at the tail on issue,
// responses are written into their slot in any order and leave from the head
// in issue order. A response for the empty head slot falls through directly.

module reorder_buffer (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // ID allocation
  input  logic                                  id_req_i,
  output logic [shim_pkg::rob_id_width-1:0]     id_o,
  output logic                                  full_o,
  // Response write
  input  logic                                  push_i,
  input  shim_pkg::dresp_t                      resp_i,
  // In-order read
  output logic [shim_pkg::data_width-1:0]       data_o,
  output logic                                  error_o,
  output logic                                  valid_o,
  input  logic                                  pop_i
);

  localparam int unsigned depth = shim_pkg::max_outstanding;
  localparam int unsigned id_w  = shim_pkg::rob_id_width;

  logic [shim_pkg::data_width-1:0] data_mem [depth];
  logic                            error_mem [depth];

  logic [depth-1:0] slot_valid_q;
  logic [id_w-1:0]  head_q;
  logic [id_w-1:0]  tail_q;
  logic [id_w:0]    count_q;

  logic head_ready;
  logic bypass;
  logic pop_fire;

  assign head_ready = slot_valid_q[head_q];
  assign bypass     = push_i && (resp_i.id == head_q) && !head_ready;

  assign valid_o = head_ready || bypass;
  assign data_o  = head_ready ? data_mem[head_q] : resp_i.data;
  assign error_o = head_ready ? error_mem[head_q] : resp_i.error;

  assign pop_fire = valid_o && pop_i;

  assign id_o   = tail_q;
  assign full_o = (count_q == (id_w + 1)'(depth));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_valid_q <= '0;
      head_q       <= '0;
      tail_q       <= '0;
      count_q      <= '0;
    end else begin
      // Keep the response unless it left through the bypass right away
      if (push_i && !(bypass && pop_i)) begin
        slot_valid_q[resp_i.id] <= 1'b1;
      end
      if (pop_fire) begin
        slot_valid_q[head_q] <= 1'b0;
        head_q               <= head_q + 1'b1;
      end
      if (id_req_i) begin
        tail_q <= tail_q + 1'b1;
      end
      case ({id_req_i, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_mem[resp_i.id]  <= resp_i.data;
      error_mem[resp_i.id] <= resp_i.error;
    end
  end

endmodule

// ==== src/id_fifo.sv ====
// Queue of reorder IDs for reads in flight on the SoC port.
// The SoC answers in order, so the head always names the next response.

module id_fifo (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              push_i,
  input  logic [shim_pkg::rob_id_width-1:0] id_i,
  input  logic                              pop_i,
  output logic [shim_pkg::rob_id_width-1:0] id_o
);

  localparam int unsigned depth = shim_pkg::max_outstanding;
  localparam int unsigned ptr_w = $clog2(depth);

  logic [shim_pkg::rob_id_width-1:0] mem [depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= id_i;
    end
  end

  assign id_o = mem[rd_ptr_q];

endmodule

// ==== src/addr_demux.sv ====
// Routes a core request to one of the TCDM banks or the SoC port by address
// and merges the target responses back, one per cycle, in round-robin order.

module addr_demux (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  // Core side request
  input  shim_pkg::dreq_t                              req_i,
  input  logic                                         req_valid_i,
  output logic                                         req_ready_o,
  // Target requests
  output shim_pkg::dreq_t  [shim_pkg::num_targets-1:0] out_req_o,
  output logic             [shim_pkg::num_targets-1:0] out_valid_o,
  input  logic             [shim_pkg::num_targets-1:0] out_ready_i,
  // Target responses
  input  shim_pkg::dresp_t [shim_pkg::num_targets-1:0] out_resp_i,
  input  logic             [shim_pkg::num_targets-1:0] out_resp_valid_i,
  output logic             [shim_pkg::num_targets-1:0] out_resp_ready_o,
  // Merged response, always taken by the reorder buffer
  output shim_pkg::dresp_t                             resp_o,
  output logic                                         resp_valid_o
);

  localparam int unsigned n         = shim_pkg::num_targets;
  localparam int unsigned sel_width = $clog2(n);

  logic                                in_tcdm;
  logic [shim_pkg::tcdm_bank_bits-1:0] bank;
  logic [sel_width-1:0]                sel;

  logic [sel_width-1:0] rr_q;
  logic [sel_width-1:0] grant;
  logic                 grant_valid;

  // Address decode
  assign in_tcdm = (req_i.addr >= shim_pkg::tcdm_base) && (req_i.addr < shim_pkg::tcdm_end);
  assign bank    = req_i.addr[shim_pkg::byte_offset_bits +: shim_pkg::tcdm_bank_bits];
  assign sel     = in_tcdm ? sel_width'(bank) : sel_width'(shim_pkg::soc_target);

  assign req_ready_o = out_ready_i[sel];

  always_comb begin
    for (int unsigned t = 0; t < n; t++) begin
      out_req_o[t]   = req_i;
      out_valid_o[t] = req_valid_i && (sel == sel_width'(t));
    end
  end

  // Search from the pointer for the first target with a response
  always_comb begin
    int unsigned idx;
    grant       = rr_q;
    grant_valid = 1'b0;
    for (int unsigned i = 0; i < n; i++) begin
      idx = int'(rr_q) + i;
      if (idx >= n) begin
        idx = idx - n;
      end
      if (!grant_valid && out_resp_valid_i[idx]) begin
        grant       = sel_width'(idx);
        grant_valid = 1'b1;
      end
    end
  end

  always_comb begin
    for (int unsigned t = 0; t < n; t++) begin
      out_resp_ready_o[t] = grant_valid && (grant == sel_width'(t));
    end
  end

  assign resp_o       = out_resp_i[grant];
  assign resp_valid_o = grant_valid;

  // Winner gets lowest priority next time
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q <= '0;
    end else if (grant_valid) begin
      if (grant == sel_width'(n - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= grant + 1'b1;
      end
    end
  end

endmodule

// ==== src/tcdm_shim.sv ====
// Data port of the core. Turns ready/valid loads and stores into requests for
// two TCDM banks and one SoC port, and returns read data in issue order.

module tcdm_shim (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  // Core request
  input  shim_pkg::dreq_noid_t                      data_q_i,
  input  logic                                      data_qvalid_i,
  output logic                                      data_qready_o,
  // Core response
  output logic [shim_pkg::data_width-1:0]           data_pdata_o,
  output logic                                      data_perror_o,
  output logic                                      data_pvalid_o,
  input  logic                                      data_pready_i,
  // TCDM banks
  output shim_pkg::dreq_t  [shim_pkg::nr_tcdm-1:0]  tcdm_req_o,
  output logic             [shim_pkg::nr_tcdm-1:0]  tcdm_req_valid_o,
  input  logic             [shim_pkg::nr_tcdm-1:0]  tcdm_req_ready_i,
  input  shim_pkg::dresp_t [shim_pkg::nr_tcdm-1:0]  tcdm_resp_i,
  input  logic             [shim_pkg::nr_tcdm-1:0]  tcdm_resp_valid_i,
  output logic             [shim_pkg::nr_tcdm-1:0]  tcdm_resp_ready_o,
  // SoC port
  output shim_pkg::dreq_t                           soc_q_o,
  output logic                                      soc_qvalid_o,
  input  logic                                      soc_qready_i,
  input  logic [shim_pkg::data_width-1:0]           soc_pdata_i,
  input  logic                                      soc_perror_i,
  input  logic                                      soc_pvalid_i,
  output logic                                      soc_pready_o
);

  localparam int unsigned n = shim_pkg::num_targets;

  shim_pkg::dreq_t                   core_req;
  shim_pkg::dreq_t  [n-1:0]          target_req;
  logic             [n-1:0]          target_req_valid;
  logic             [n-1:0]          target_req_ready;
  shim_pkg::dresp_t [n-1:0]          target_resp;
  logic             [n-1:0]          target_resp_valid;
  logic             [n-1:0]          target_resp_ready;

  logic                              demux_ready;
  logic                              rob_full;
  logic                              rob_push;
  logic                              read_accept;
  logic [shim_pkg::rob_id_width-1:0] rob_id;
  logic [shim_pkg::rob_id_width-1:0] soc_head_id;
  shim_pkg::dresp_t                  rob_resp;
  shim_pkg::dresp_t                  soc_resp;

  // Tag the core request with the next free reorder slot
  assign core_req = '{
    addr:  data_q_i.addr,
    write: data_q_i.write,
    amo:   data_q_i.amo,
    data:  data_q_i.data,
    strb:  data_q_i.strb,
    id:    rob_id
  };

  // Hold all requests while every reorder slot is taken
  assign data_qready_o = demux_ready && !rob_full;
  assign read_accept   = data_qvalid_i && data_qready_o && !data_q_i.write;

  // SoC responses take their ID from the in-order queue
  assign soc_resp = '{data: soc_pdata_i, id: soc_head_id, error: soc_perror_i};

  assign target_req_ready  = {soc_qready_i, tcdm_req_ready_i};
  assign target_resp       = {soc_resp, tcdm_resp_i};
  assign target_resp_valid = {soc_pvalid_i, tcdm_resp_valid_i};

  assign tcdm_req_o        = target_req[shim_pkg::nr_tcdm-1:0];
  assign tcdm_req_valid_o  = target_req_valid[shim_pkg::nr_tcdm-1:0];
  assign tcdm_resp_ready_o = target_resp_ready[shim_pkg::nr_tcdm-1:0];
  assign soc_q_o           = target_req[shim_pkg::soc_target];
  assign soc_qvalid_o      = target_req_valid[shim_pkg::soc_target];
  assign soc_pready_o      = target_resp_ready[shim_pkg::soc_target];

  addr_demux i_addr_demux (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_i            (core_req),
    .req_valid_i      (data_qvalid_i && !rob_full),
    .req_ready_o      (demux_ready),
    .out_req_o        (target_req),
    .out_valid_o      (target_req_valid),
    .out_ready_i      (target_req_ready),
    .out_resp_i       (target_resp),
    .out_resp_valid_i (target_resp_valid),
    .out_resp_ready_o (target_resp_ready),
    .resp_o           (rob_resp),
    .resp_valid_o     (rob_push)
  );

  reorder_buffer i_reorder_buffer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .id_req_i (read_accept),
    .id_o     (rob_id),
    .full_o   (rob_full),
    .push_i   (rob_push),
    .resp_i   (rob_resp),
    .data_o   (data_pdata_o),
    .error_o  (data_perror_o),
    .valid_o  (data_pvalid_o),
    .pop_i    (data_pready_i)
  );

  id_fifo i_soc_id_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (soc_qvalid_o && soc_qready_i && !soc_q_o.write),
    .id_i    (soc_q_o.id),
    .pop_i   (soc_pvalid_i && soc_pready_o),
    .id_o    (soc_head_id)
  );

endmodule

// ==== tests/shim_checker.sv ====
// Assertions bound into the data port. Tracks accepted reads to check response
// order and values, request routing, response arbitration and the read limit.

module shim_checker (
  input logic                                    clk_i,
  input logic                                    reset_i,
  input shim_pkg::dreq_noid_t                    data_q_i,
  input logic                                    data_qvalid_i,
  input logic                                    data_qready_i,
  input logic [shim_pkg::data_width-1:0]         data_pdata_i,
  input logic                                    data_perror_i,
  input logic                                    data_pvalid_i,
  input logic                                    data_pready_i,
  input shim_pkg::dreq_t [shim_pkg::nr_tcdm-1:0] tcdm_req_i,
  input logic [shim_pkg::nr_tcdm-1:0]            tcdm_req_valid_i,
  input logic [shim_pkg::nr_tcdm-1:0]            tcdm_resp_valid_i,
  input logic [shim_pkg::nr_tcdm-1:0]            tcdm_resp_ready_i,
  input shim_pkg::dreq_t                         soc_q_i,
  input logic                                    soc_qvalid_i,
  input logic                                    soc_pvalid_i,
  input logic                                    soc_pready_i
);

  int unsigned error_count = 0;

  logic [31:0]     addr_mem [16];
  logic [3:0]      wr_ptr_q;
  logic [3:0]      rd_ptr_q;
  logic [4:0]      outstanding_q;
  logic [31:0]     head_addr;
  logic            req_in_tcdm;
  logic            head_in_tcdm;
  logic            read_acc;
  logic            resp_fire;
  logic [2:0]      exp_target;
  logic [2:0]      resp_valid;
  logic [2:0]      resp_ready;
  shim_pkg::dreq_t routed;

  assign read_acc     = data_qvalid_i && data_qready_i && !data_q_i.write;
  assign resp_fire    = data_pvalid_i && data_pready_i;
  assign head_addr    = addr_mem[rd_ptr_q];
  assign req_in_tcdm  = data_q_i.addr >= shim_pkg::tcdm_base &&
                        data_q_i.addr < shim_pkg::tcdm_base + shim_pkg::tcdm_size;
  assign head_in_tcdm = head_addr >= shim_pkg::tcdm_base &&
                        head_addr < shim_pkg::tcdm_base + shim_pkg::tcdm_size;
  // One-hot target with the SoC port on top
  assign exp_target   = req_in_tcdm ? (data_q_i.addr[2] ? 3'b010 : 3'b001) : 3'b100;
  assign routed       = req_in_tcdm ? tcdm_req_i[data_q_i.addr[2]] : soc_q_i;
  assign resp_valid   = {soc_pvalid_i, tcdm_resp_valid_i};
  assign resp_ready   = {soc_pready_i, tcdm_resp_ready_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      outstanding_q <= '0;
    end else begin
      if (read_acc) begin
        addr_mem[wr_ptr_q] <= data_q_i.addr;
        wr_ptr_q           <= wr_ptr_q + 1'b1;
      end
      if (resp_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      outstanding_q <= outstanding_q + 5'(read_acc) - 5'(resp_fire);
    end
  end

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    (outstanding_q == 5'd0 && !data_qvalid_i) |->
      ({soc_qvalid_i, tcdm_req_valid_i} == 3'b000 && !data_pvalid_i))
    else begin
      $error("[FAIL] %0t: valid output raised without a request", $time);
      error_count++;
    end

  a_resp_order: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_fire |-> (outstanding_q != 5'd0 &&
      data_pdata_i == (head_in_tcdm ? head_addr ^ 32'hA5A5_A5A5 : ~head_addr) &&
      data_perror_i == (!head_in_tcdm && head_addr[20])))
    else begin
      $error("[FAIL] %0t: response for 0x%08h is wrong or out of order", $time, head_addr);
      error_count++;
    end

  a_routing: assert property (@(posedge clk_i) disable iff (reset_i)
    (data_qvalid_i && data_qready_i) |->
      ({soc_qvalid_i, tcdm_req_valid_i} == exp_target &&
       {routed.addr, routed.write, routed.amo, routed.data, routed.strb} == data_q_i))
    else begin
      $error("[FAIL] %0t: request 0x%08h routed wrongly", $time, data_q_i.addr);
      error_count++;
    end

  // Exactly one waiting target is taken per cycle
  a_resp_merge: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(resp_ready) && (resp_ready & ~resp_valid) == 3'b000 &&
    (resp_valid == 3'b000 || resp_ready != 3'b000))
    else begin
      $error("[FAIL] %0t: response ready %b for valid %b", $time, resp_ready,
             resp_valid);
      error_count++;
    end

  a_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_q <= 5'd8 && (outstanding_q != 5'd8 || !data_qready_i))
    else begin
      $error("[FAIL] %0t: %0d reads outstanding", $time, outstanding_q);
      error_count++;
    end

endmodule

// ==== tests/tb_tcdm_shim.sv ====
// Testbench for the core data port. Models two TCDM banks and the SoC port,
// drives random loads and stores and reports per test from the bound checker.

module tb_tcdm_shim;

  localparam int unsigned nb             = shim_pkg::nr_tcdm;
  localparam int unsigned planned_cycles = 20 + 300 + 200 + 200 + 300;

  typedef struct packed {
    shim_pkg::dresp_t resp;
    int unsigned      due;
  } pend_t;

  logic                            clk_i;
  logic                            reset_i;
  shim_pkg::dreq_noid_t            data_q_i;
  logic                            data_qvalid_i;
  logic                            data_qready_o;
  logic [shim_pkg::data_width-1:0] data_pdata_o;
  logic                            data_perror_o;
  logic                            data_pvalid_o;
  logic                            data_pready_i;
  shim_pkg::dreq_t  [nb-1:0]       tcdm_req_o;
  logic             [nb-1:0]       tcdm_req_valid_o;
  logic             [nb-1:0]       tcdm_req_ready_i;
  shim_pkg::dresp_t [nb-1:0]       tcdm_resp_i;
  logic             [nb-1:0]       tcdm_resp_valid_i;
  logic             [nb-1:0]       tcdm_resp_ready_o;
  shim_pkg::dreq_t                 soc_q_o;
  logic                            soc_qvalid_o;
  logic                            soc_qready_i;
  logic [shim_pkg::data_width-1:0] soc_pdata_i;
  logic                            soc_perror_i;
  logic                            soc_pvalid_i;
  logic                            soc_pready_o;

  integer      seed        = 32'ha256ebe8;
  int unsigned cycle       = 0;
  int unsigned read_count  = 0;
  int unsigned resp_count  = 0;
  int unsigned last_errors = 0;
  int unsigned pass_count  = 0;
  int unsigned fail_count  = 0;
  logic        hold_pready = 1'b0;
  pend_t       pend_q [nb+1][$];

  tcdm_shim tcdm_shim_i (.*);

  bind tcdm_shim shim_checker checker_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .data_q_i          (data_q_i),
    .data_qvalid_i     (data_qvalid_i),
    .data_qready_i     (data_qready_o),
    .data_pdata_i      (data_pdata_o),
    .data_perror_i     (data_perror_o),
    .data_pvalid_i     (data_pvalid_o),
    .data_pready_i     (data_pready_i),
    .tcdm_req_i        (tcdm_req_o),
    .tcdm_req_valid_i  (tcdm_req_valid_o),
    .tcdm_resp_valid_i (tcdm_resp_valid_i),
    .tcdm_resp_ready_i (tcdm_resp_ready_o),
    .soc_q_i           (soc_q_o),
    .soc_qvalid_i      (soc_qvalid_o),
    .soc_pvalid_i      (soc_pvalid_i),
    .soc_pready_i      (soc_pready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #(4 * planned_cycles * 10);
    $display("Timeout: the tests did not finish in time");
    $display("Test FAILED");
    $finish;
  end

  always @(posedge clk_i) begin
    if (data_qvalid_i && data_qready_o && !data_q_i.write) read_count <= read_count + 1;
    if (data_pvalid_o && data_pready_i) resp_count <= resp_count + 1;
  end

  // Bank and SoC target models
  // Index nb is the SoC port and answers in order
  initial begin
    pend_t       p;
    logic [31:0] r;
    tcdm_req_ready_i  = '1;
    tcdm_resp_i       = '0;
    tcdm_resp_valid_i = '0;
    soc_qready_i      = 1'b0;
    soc_pdata_i       = '0;
    soc_perror_i      = 1'b0;
    soc_pvalid_i      = 1'b0;
    data_pready_i     = 1'b0;
    forever begin
      @(posedge clk_i);
      cycle++;
      for (int unsigned b = 0; b < nb; b++) begin
        if (tcdm_resp_valid_i[b] && tcdm_resp_ready_o[b]) void'(pend_q[b].pop_front());
        if (tcdm_req_valid_o[b] && tcdm_req_ready_i[b] && !tcdm_req_o[b].write) begin
          p.resp.data  = tcdm_req_o[b].addr ^ 32'hA5A5_A5A5;
          p.resp.id    = tcdm_req_o[b].id;
          p.resp.error = 1'b0;
          p.due        = cycle + 1 + ($unsigned($random(seed)) % 6);
          pend_q[b].push_back(p);
        end
      end
      if (soc_pvalid_i && soc_pready_o) void'(pend_q[nb].pop_front());
      if (soc_qvalid_o && soc_qready_i && !soc_q_o.write) begin
        p.resp.data  = ~soc_q_o.addr;
        p.resp.id    = '0;
        p.resp.error = soc_q_o.addr[20];
        p.due        = cycle + 1 + ($unsigned($random(seed)) % 5);
        pend_q[nb].push_back(p);
      end
      r = $random(seed);
      #1;
      for (int unsigned b = 0; b < nb; b++) begin
        tcdm_resp_valid_i[b] = pend_q[b].size() > 0 && pend_q[b][0].due <= cycle;
        tcdm_resp_i[b]       = tcdm_resp_valid_i[b] ? pend_q[b][0].resp : '0;
        tcdm_req_ready_i[b]  = r[4 + 2 * b +: 2] != 2'b00;
      end
      soc_pvalid_i  = pend_q[nb].size() > 0 && pend_q[nb][0].due <= cycle;
      soc_pdata_i   = soc_pvalid_i ? pend_q[nb][0].resp.data : '0;
      soc_perror_i  = soc_pvalid_i && pend_q[nb][0].resp.error;
      soc_qready_i  = r[1:0] != 2'b00;
      data_pready_i = !hold_pready && (r[3:2] != 2'b00);
    end
  end

  // Bank 0 or 1, the SoC range, or an address just outside the TCDM region
  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    case (r[31:30])
      2'd0, 2'd1: return shim_pkg::tcdm_base + {16'h0, r[15:3], r[0], 2'b00};
      2'd2:       return {8'h20, r[23:2], 2'b00};
      default:    return r[2] ? shim_pkg::tcdm_base - 32'd4
                              : shim_pkg::tcdm_base + shim_pkg::tcdm_size;
    endcase
  endfunction

  task automatic issue(input logic is_write);
    shim_pkg::dreq_noid_t req;
    req.addr      = rand_addr();
    req.write     = is_write;
    req.amo       = shim_pkg::amo_op_e'({1'b0, 3'($random(seed))});
    req.data      = $random(seed);
    req.strb      = 4'($random(seed));
    data_q_i      = req;
    data_qvalid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!data_qready_o);
    #1;
  endtask

  task automatic issue_many(input int unsigned n, input int unsigned write_pct);
    for (int unsigned i = 0; i < n; i++) begin
      issue(($unsigned($random(seed)) % 100) < write_pct);
    end
    data_qvalid_i = 1'b0;
  endtask

  task automatic drain();
    while (resp_count != read_count) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic report(input string name);
    int unsigned errs;
    errs        = tcdm_shim_i.checker_i.error_count - last_errors;
    last_errors = tcdm_shim_i.checker_i.error_count;
    if (errs == 0) begin
      $display("test %s: ok", name);
      pass_count++;
    end else begin
      $display("[FAIL] %0t: test %s, %0d assertion failures", $time, name, errs);
      fail_count++;
    end
  endtask

  initial begin
    data_q_i      = '0;
    data_qvalid_i = 1'b0;
    reset_i       = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    repeat (20) @(posedge clk_i);
    #1;
    report("reset idle");
    issue_many(60, 0);
    drain();
    report("random reads");
    issue_many(40, 50);
    drain();
    report("routing");
    hold_pready = 1'b1;
    fork
      issue_many(12, 0);
      begin
        while (read_count - resp_count < 8) @(posedge clk_i);
        repeat (20) @(posedge clk_i);
        hold_pready = 1'b0;
      end
    join
    drain();
    report("back-pressure");
    issue_many(80, 30);
    drain();
    report("mixed writes and reads");
    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/shim_pkg.sv
src/reorder_buffer.sv
src/id_fifo.sv
src/addr_demux.sv
src/tcdm_shim.sv
tests/shim_checker.sv
tests/tb_tcdm_shim.sv

// ==== Makefile ====
# Verilator build and run of the data port testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_shim
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell cat all.f)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log for the pass line"
	@echo "  clean  remove the build directory and the log"

$(BUILD_DIR)/V$(TOP): all.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
